/* rtl/color_pkg.sv */
package color_pkg;

  // widths that carry a meaning
  typedef logic [11:0] pxl_t;       // rgb444, red on top, blue at the bottom
  typedef logic [3:0]  comp_t;      // one color component
  typedef logic [14:0] addr_t;      // pixel address, 0 to 19199
  typedef logic [7:0]  col_t;       // column, 0 to 159
  typedef logic [6:0]  row_t;       // row, 0 to 119
  typedef logic [2:0]  bin_t;       // histogram bin index
  typedef logic [10:0] bin_cnt_t;   // up to 1664 per bin
  typedef logic [13:0] total_t;     // up to 13312 in the inner frame
  typedef logic [2:0]  filter_t;    // one bit per primary: r g b

  typedef enum logic {
    SCAN_IDLE,
    SCAN_RUN
  } scan_state_t;

  // qqvga image
  localparam int img_cols   = 160;
  localparam int img_rows   = 120;
  localparam int img_pxls   = img_cols * img_rows;  // 19200

  // border taken away on each side before the histogram
  localparam int out_cols   = 16;
  localparam int out_rows   = 8;

  localparam int hist_bins  = 8;
  localparam int bin_cols   = 16;                   // 128 inner columns / 8 bins
  localparam int inner_pxls = 13312;                // 128 x 104
  localparam int bin_max    = 1664;                 // 104 rows x 16 columns

  // component difference limits
  localparam comp_t simil_limit = 4'd1;  // at or below: similar
  localparam comp_t vdif_limit  = 4'd2;  // at or above: very different

  // filter codes
  localparam filter_t filt_none = 3'b000;  // everything passes
  localparam filter_t filt_red  = 3'b100;
  localparam filter_t filt_grn  = 3'b010;
  localparam filter_t filt_blu  = 3'b001;
  localparam filter_t filt_yel  = 3'b110;  // red and green
  localparam filter_t filt_mag  = 3'b101;  // red and blue
  localparam filter_t filt_cya  = 3'b011;  // green and blue
  localparam filter_t filt_whi  = 3'b111;  // bright gray

endpackage

/* rtl/frame_scan.sv */
`timescale 1ns/100ps

module frame_scan (
  input  logic               clk,
  input  logic               rst,
  input  logic               new_frame_i,  // one cycle, only seen when idle
  input  color_pkg::filter_t filter_i,
  output color_pkg::filter_t filter_o,     // held for the whole frame
  output color_pkg::addr_t   rd_addr_o,    // to the original image memory
  output logic               tag_valid_o,
  output logic               tag_first_o,
  output logic               tag_last_o,
  output logic               tag_inner_o,
  output color_pkg::addr_t   tag_addr_o,
  output color_pkg::bin_t    tag_bin_o
);

  color_pkg::scan_state_t state;
  color_pkg::addr_t       addr;
  color_pkg::col_t        col;
  color_pkg::row_t        row;
  color_pkg::col_t        in_col;     // column inside the inner frame
  color_pkg::bin_t        bin;
  logic                   run;
  logic                   end_ln;
  logic                   end_frame;
  logic                   first;
  logic                   inner;

  // tag stages: [0] lines up with the memory data, [1] with the classifier output
  logic [1:0]             valid_d;
  logic [1:0]             first_d;
  logic [1:0]             last_d;
  logic [1:0]             inner_d;
  color_pkg::addr_t       addr_d [2];
  color_pkg::bin_t        bin_d  [2];

  assign run       = (state == color_pkg::SCAN_RUN);
  assign end_ln    = (col == color_pkg::col_t'(color_pkg::img_cols - 1));
  assign end_frame = (addr == color_pkg::addr_t'(color_pkg::img_pxls - 1));
  assign first     = run && (addr == '0);

  // inner frame is columns 16..143, rows 8..111
  assign inner = (col >= color_pkg::out_cols) &&
                 (col <  color_pkg::img_cols - color_pkg::out_cols) &&
                 (row >= color_pkg::out_rows) &&
                 (row <  color_pkg::img_rows - color_pkg::out_rows);

  // outside the inner frame the bin is garbage, inner gates it later
  assign in_col = col - color_pkg::col_t'(color_pkg::out_cols);
  assign bin    = color_pkg::bin_t'(in_col / color_pkg::bin_cols);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= color_pkg::SCAN_IDLE;
      addr     <= '0;
      col      <= '0;
      row      <= '0;
      filter_o <= color_pkg::filt_none;
    end else begin
      case (state)
        color_pkg::SCAN_IDLE: begin
          if (new_frame_i) begin
            state    <= color_pkg::SCAN_RUN;
            filter_o <= filter_i;  // one filter per frame
          end
        end
        color_pkg::SCAN_RUN: begin
          if (end_frame) begin
            state <= color_pkg::SCAN_IDLE;
            addr  <= '0;
            col   <= '0;
            row   <= '0;
          end else begin
            addr <= addr + 1'b1;
            if (end_ln) begin
              col <= '0;
              row <= row + 1'b1;
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        default: state <= color_pkg::SCAN_IDLE;
      endcase
    end
  end

  assign rd_addr_o = addr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_d <= '0;
      first_d <= '0;
      last_d  <= '0;
    end else begin
      valid_d <= {valid_d[0], run};
      first_d <= {first_d[0], first};
      last_d  <= {last_d[0], run & end_frame};
    end
  end

  // payload of the tag, only looked at with valid
  always_ff @(posedge clk) begin
    inner_d   <= {inner_d[0], inner};
    addr_d[0] <= addr;
    addr_d[1] <= addr_d[0];
    bin_d[0]  <= bin;
    bin_d[1]  <= bin_d[0];
  end

  assign tag_valid_o = valid_d[1];
  assign tag_first_o = first_d[1];
  assign tag_last_o  = last_d[1];
  assign tag_inner_o = inner_d[1];
  assign tag_addr_o  = addr_d[1];
  assign tag_bin_o   = bin_d[1];

  a_addr_range: assert property (@(posedge clk) disable iff (rst)
    run |-> rd_addr_o < color_pkg::addr_t'(color_pkg::img_pxls));

endmodule

/* rtl/color_classify.sv */
`timescale 1ns/100ps

module color_classify (
  input  logic               clk,
  input  logic               rst,
  input  color_pkg::pxl_t    pxl_i,     // one cycle after the read address
  input  color_pkg::filter_t filter_i,
  output logic               pass_o,    // pixel passed the filter
  output color_pkg::pxl_t    pxl_o      // pixel or black
);

  color_pkg::comp_t r;
  color_pkg::comp_t g;
  color_pkg::comp_t b;
  color_pkg::comp_t rg_dif;  // absolute differences
  color_pkg::comp_t rb_dif;
  color_pkg::comp_t gb_dif;
  color_pkg::pxl_t  pxl_q;
  logic             r_gt_g;
  logic             r_gt_b;
  logic             g_gt_b;
  logic             rg_sim;
  logic             rb_sim;
  logic             gb_sim;
  logic             rg_vdif;
  logic             rb_vdif;
  logic             gb_vdif;
  logic             is_red;
  logic             is_grn;
  logic             is_blu;
  logic             is_yel;
  logic             is_mag;
  logic             is_cya;
  logic             is_gra;
  logic             is_whi;
  logic             pass_nxt;
  logic             pass_q;

  assign {r, g, b} = pxl_i;

  assign r_gt_g = (r > g);
  assign r_gt_b = (r > b);
  assign g_gt_b = (g > b);

  assign rg_dif = r_gt_g ? r - g : g - r;
  assign rb_dif = r_gt_b ? r - b : b - r;
  assign gb_dif = g_gt_b ? g - b : b - g;

  assign rg_sim  = (rg_dif <= color_pkg::simil_limit);
  assign rb_sim  = (rb_dif <= color_pkg::simil_limit);
  assign gb_sim  = (gb_dif <= color_pkg::simil_limit);
  assign rg_vdif = (rg_dif >= color_pkg::vdif_limit);
  assign rb_vdif = (rb_dif >= color_pkg::vdif_limit);
  assign gb_vdif = (gb_dif >= color_pkg::vdif_limit);

  // one branch per ordering of the three components
  always_comb begin
    is_red = 1'b0;
    is_grn = 1'b0;
    is_blu = 1'b0;
    is_yel = 1'b0;
    is_mag = 1'b0;
    is_cya = 1'b0;
    is_gra = 1'b0;
    if (r_gt_g && r_gt_b && g_gt_b) begin             // r > g > b
      if (rg_vdif)      is_red = 1'b1;
      else if (rb_sim)  is_gra = 1'b1;
      else if (gb_vdif) is_yel = 1'b1;                // r and g close, b well below
    end else if (r_gt_g && r_gt_b) begin              // r > b >= g
      if (rb_vdif)      is_red = 1'b1;
      else if (rg_sim)  is_gra = 1'b1;
      else if (gb_vdif) is_mag = 1'b1;
    end else if (r_gt_g) begin                        // b >= r > g
      if (rb_vdif)      is_blu = 1'b1;
      else if (gb_sim)  is_gra = 1'b1;
      else if (rg_vdif) is_mag = 1'b1;
    end else if (r_gt_b) begin                        // g >= r > b
      if (rg_vdif)      is_grn = 1'b1;
      else if (rb_vdif) is_yel = 1'b1;
      else if (gb_sim)  is_gra = 1'b1;
    end else if (g_gt_b) begin                        // g > b >= r
      if (gb_vdif)      is_grn = 1'b1;
      else if (rb_vdif) is_cya = 1'b1;
      else if (rg_sim)  is_gra = 1'b1;
    end else begin                                    // b >= g >= r
      if (gb_vdif)      is_blu = 1'b1;
      else if (rb_sim)  is_gra = 1'b1;
      else if (rg_vdif) is_cya = 1'b1;
    end
  end

  // white is a gray with every component at 12 or more
  assign is_whi = is_gra & (&r[3:2]) & (&g[3:2]) & (&b[3:2]);

  always_comb begin
    case (filter_i)
      color_pkg::filt_none: pass_nxt = 1'b1;
      color_pkg::filt_red:  pass_nxt = is_red;
      color_pkg::filt_grn:  pass_nxt = is_grn;
      color_pkg::filt_blu:  pass_nxt = is_blu;
      color_pkg::filt_yel:  pass_nxt = is_yel;
      color_pkg::filt_mag:  pass_nxt = is_mag;
      color_pkg::filt_cya:  pass_nxt = is_cya;
      color_pkg::filt_whi:  pass_nxt = is_whi;
      default:              pass_nxt = 1'b1;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) pass_q <= 1'b0;
    else     pass_q <= pass_nxt;
  end

  always_ff @(posedge clk) begin
    pxl_q <= pxl_i;
  end

  assign pass_o = pass_q;
  assign pxl_o  = pass_q ? pxl_q : '0;  // failing pixels go out black

  // the six orderings never hand out two classes at once
  a_one_class: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(pxl_i) |-> $onehot0({is_red, is_grn, is_blu, is_yel,
                                     is_mag, is_cya, is_gra}));

endmodule

/* rtl/hist_accum.sv */
`timescale 1ns/100ps

module hist_accum (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            tag_valid_i,
  input  logic                                            tag_first_i,
  input  logic                                            tag_last_i,
  input  logic                                            tag_inner_i,
  input  logic                                            pass_i,
  input  color_pkg::bin_t                                 tag_bin_i,
  output color_pkg::bin_cnt_t [color_pkg::hist_bins-1:0] hist_o,  // bin 0 lowest
  output color_pkg::total_t                               color_total_o,
  output logic                                            frame_done_o
);

  color_pkg::bin_cnt_t bin_cnt [color_pkg::hist_bins];  // working counts
  color_pkg::bin_cnt_t bin_nxt [color_pkg::hist_bins];
  color_pkg::total_t   total_cnt;
  color_pkg::total_t   total_nxt;
  logic                restart;
  logic                hit;

  assign restart = tag_valid_i & tag_first_i;            // new frame, drop old counts
  assign hit     = tag_valid_i & tag_inner_i & pass_i;   // counted pixel

  // next counts include the pixel on the tag, so the snapshot on last is complete
  always_comb begin
    for (int i = 0; i < color_pkg::hist_bins; i++) begin
      bin_nxt[i] = restart ? '0 : bin_cnt[i];
      if (hit && (tag_bin_i == color_pkg::bin_t'(i)))
        bin_nxt[i] = bin_nxt[i] + 1'b1;
    end
    total_nxt = restart ? '0 : total_cnt;
    if (hit)
      total_nxt = total_nxt + 1'b1;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < color_pkg::hist_bins; i++) begin
        bin_cnt[i] <= '0;
        hist_o[i]  <= '0;
      end
      total_cnt     <= '0;
      color_total_o <= '0;
      frame_done_o  <= 1'b0;
    end else begin
      frame_done_o <= tag_valid_i & tag_last_i;  // cycle after the last write
      if (tag_valid_i) begin
        for (int i = 0; i < color_pkg::hist_bins; i++)
          bin_cnt[i] <= bin_nxt[i];
        total_cnt <= total_nxt;
        if (tag_last_i) begin
          // results hold until the next frame ends
          for (int i = 0; i < color_pkg::hist_bins; i++)
            hist_o[i] <= bin_nxt[i];
          color_total_o <= total_nxt;
        end
      end
    end
  end

  // a bin covers 104 x 16 inner pixels, nothing more
  for (genvar gi = 0; gi < color_pkg::hist_bins; gi++) begin : g_bin_chk
    a_bin_max: assert property (@(posedge clk) disable iff (rst)
      bin_cnt[gi] <= color_pkg::bin_cnt_t'(color_pkg::bin_max));
  end

  a_total_max: assert property (@(posedge clk) disable iff (rst)
    total_cnt <= color_pkg::total_t'(color_pkg::inner_pxls));

  // frames are far longer than one cycle, done never repeats back to back
  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    frame_done_o |=> !frame_done_o);

endmodule

/* rtl/color_proc.sv */
`timescale 1ns/100ps

module color_proc (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            new_frame_i,
  input  color_pkg::filter_t                              filter_i,
  input  color_pkg::pxl_t                                 orig_pxl_i,   // 1 cycle after addr
  output color_pkg::addr_t                                orig_addr_o,
  output logic                                            proc_we_o,
  output color_pkg::addr_t                                proc_addr_o,
  output color_pkg::pxl_t                                 proc_pxl_o,
  output logic                                            frame_done_o,
  output color_pkg::bin_cnt_t [color_pkg::hist_bins-1:0] hist_o,
  output color_pkg::total_t                               color_total_o
);

  color_pkg::filter_t filter;     // filter of the frame in flight
  color_pkg::bin_t    tag_bin;
  logic               tag_valid;
  logic               tag_first;
  logic               tag_last;
  logic               tag_inner;
  logic               pass;

  // decode stage: scan the frame, tags come out lined up with the classifier
  frame_scan u_frame_scan (
    .clk         (clk),
    .rst         (rst),
    .new_frame_i (new_frame_i),
    .filter_i    (filter_i),
    .filter_o    (filter),
    .rd_addr_o   (orig_addr_o),
    .tag_valid_o (tag_valid),
    .tag_first_o (tag_first),
    .tag_last_o  (tag_last),
    .tag_inner_o (tag_inner),
    .tag_addr_o  (proc_addr_o),   // write address comes straight from the tag
    .tag_bin_o   (tag_bin)
  );

  // execute stage
  color_classify u_color_classify (
    .clk      (clk),
    .rst      (rst),
    .pxl_i    (orig_pxl_i),
    .filter_i (filter),
    .pass_o   (pass),
    .pxl_o    (proc_pxl_o)
  );

  // result stage
  hist_accum u_hist_accum (
    .clk           (clk),
    .rst           (rst),
    .tag_valid_i   (tag_valid),
    .tag_first_i   (tag_first),
    .tag_last_i    (tag_last),
    .tag_inner_i   (tag_inner),
    .pass_i        (pass),
    .tag_bin_i     (tag_bin),
    .hist_o        (hist_o),
    .color_total_o (color_total_o),
    .frame_done_o  (frame_done_o)
  );

  assign proc_we_o = tag_valid;  // every valid tag is one write, no back-pressure

endmodule

/* tests/color_ref.svh */
`ifndef COLOR_REF_SVH
`define COLOR_REF_SVH

// white is split off from gray, only the white filter cares
typedef enum int {
  cls_none, cls_red, cls_grn, cls_blu, cls_yel, cls_mag, cls_cya, cls_gray, cls_white
} ref_class_t;

// class of one pixel, one branch per row of the ordering table
function automatic ref_class_t color_class(input color_pkg::pxl_t p);
  int r;
  int g;
  int b;
  int lo;  // at or below: similar
  int hi;  // at or above: very different
  ref_class_t c;
  r  = p[11:8];
  g  = p[7:4];
  b  = p[3:0];
  lo = color_pkg::simil_limit;
  hi = color_pkg::vdif_limit;
  c  = cls_none;
  if (r > g && r > b && g > b) begin
    if (r - g >= hi) c = cls_red;
    else if (r - b <= lo) c = cls_gray;
    else if (g - b >= hi) c = cls_yel;
  end else if (r > g && r > b) begin  // b >= g
    if (r - b >= hi) c = cls_red;
    else if (r - g <= lo) c = cls_gray;
    else if (b - g >= hi) c = cls_mag;
  end else if (r > g) begin           // b >= r
    if (b - r >= hi) c = cls_blu;
    else if (b - g <= lo) c = cls_gray;
    else if (r - g >= hi) c = cls_mag;
  end else if (r > b) begin           // g >= r
    if (g - r >= hi) c = cls_grn;
    else if (r - b >= hi) c = cls_yel;
    else if (g - b <= lo) c = cls_gray;
  end else if (g > b) begin           // g >= r, b >= r
    if (g - b >= hi) c = cls_grn;
    else if (b - r >= hi) c = cls_cya;
    else if (g - r <= lo) c = cls_gray;
  end else begin                      // b >= g >= r
    if (b - g >= hi) c = cls_blu;
    else if (b - r <= lo) c = cls_gray;
    else if (g - r >= hi) c = cls_cya;
  end
  if (c == cls_gray && r >= 12 && g >= 12 && b >= 12)
    c = cls_white;                    // top two bits of every component set
  return c;
endfunction

// pass rule of a filter code, no filter lets everything through
function automatic bit filter_pass(input color_pkg::pxl_t p, input color_pkg::filter_t f);
  ref_class_t c;
  c = color_class(p);
  case (f)
    color_pkg::filt_red: return c == cls_red;
    color_pkg::filt_grn: return c == cls_grn;
    color_pkg::filt_blu: return c == cls_blu;
    color_pkg::filt_yel: return c == cls_yel;
    color_pkg::filt_mag: return c == cls_mag;
    color_pkg::filt_cya: return c == cls_cya;
    color_pkg::filt_whi: return c == cls_white;
    default:             return 1'b1;
  endcase
endfunction

// histogram bin of an address, -1 on the border
function automatic int bin_of(input int a);
  int col;
  int row;
  col = a % color_pkg::img_cols;
  row = a / color_pkg::img_cols;
  if (col < color_pkg::out_cols || col >= color_pkg::img_cols - color_pkg::out_cols ||
      row < color_pkg::out_rows || row >= color_pkg::img_rows - color_pkg::out_rows)
    return -1;
  return (col - color_pkg::out_cols) / color_pkg::bin_cols;
endfunction

`endif

/* tests/tb_color_proc.sv */
`timescale 1ns/100ps

module tb_color_proc;

  `include "color_ref.svh"

  localparam int max_wait = 25000;  // cycles, a frame takes 19203
  localparam int seed     = 52;

  logic                                           clk;
  logic                                           rst;
  logic                                           new_frame_i;
  color_pkg::filter_t                             filter_i;
  color_pkg::pxl_t                                orig_pxl_i;
  color_pkg::addr_t                               orig_addr_o;
  logic                                           proc_we_o;
  color_pkg::addr_t                               proc_addr_o;
  color_pkg::pxl_t                                proc_pxl_o;
  logic                                           frame_done_o;
  color_pkg::bin_cnt_t [color_pkg::hist_bins-1:0] hist_o;
  color_pkg::total_t                              color_total_o;

  color_pkg::pxl_t  orig_mem [color_pkg::img_pxls];
  color_pkg::pxl_t  proc_mem [color_pkg::img_pxls];
  int               wr_cnt   [color_pkg::img_pxls];  // written flag, counts repeats too
  color_pkg::addr_t mem_rd_addr;  // address the memory answers in this cycle
  color_pkg::addr_t addr_d1;      // read address one and two cycles back
  color_pkg::addr_t addr_d2;
  int               cyc = 0;
  int               done_cyc = -1;  // where frame_done_o is due
  int               exp_wr_addr = 0;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  color_proc u_color_proc (.*);

  // original image, data of an address is there one cycle after the address
  always @(negedge clk) begin
    orig_pxl_i  = orig_mem[mem_rd_addr];  // address of the previous cycle
    mem_rd_addr = orig_addr_o;
  end

  task automatic value_error(input string name, input longint got, input longint exp);
    $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    $display("tests failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic timeout_error(input string what);
    $display("no %s within %0d cycles, the design seems stuck", what, max_wait);
    $display("tests failed");
    $fatal(1, "timeout");
  endtask

  // processed image, write timing and done position
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!rst) begin
      if (proc_we_o) begin
        assert (proc_addr_o == addr_d2)    // two cycles after the read
          else value_error("proc_addr_o vs read address", proc_addr_o, addr_d2);
        assert (int'(proc_addr_o) == exp_wr_addr)
          else value_error("proc_addr_o order", proc_addr_o, exp_wr_addr);
        proc_mem[proc_addr_o] = proc_pxl_o;
        wr_cnt[proc_addr_o]++;
        exp_wr_addr = (exp_wr_addr + 1) % color_pkg::img_pxls;
        if (int'(proc_addr_o) == color_pkg::img_pxls - 1)
          done_cyc = cyc + 1;
      end
      assert (frame_done_o == (cyc == done_cyc))
        else value_error("frame_done_o", frame_done_o, cyc == done_cyc);
    end
    addr_d2 = addr_d1;
    addr_d1 = orig_addr_o;
  end

  task automatic wait_done();
    for (int i = 0; i < max_wait; i++) begin
      @(negedge clk);
      if (frame_done_o)
        return;
    end
    timeout_error("frame_done_o pulse");
  endtask

  task automatic wait_addr(input int a);
    for (int i = 0; i < max_wait; i++) begin
      @(negedge clk);
      if (int'(orig_addr_o) == a)
        return;
    end
    timeout_error($sformatf("read of address %0d", a));
  endtask

  task automatic start_frame(input color_pkg::filter_t f);
    @(negedge clk);
    new_frame_i = 1'b1;
    filter_i    = f;
    @(negedge clk);
    new_frame_i = 1'b0;
    filter_i    = ~f;  // must not leak into the running frame
  endtask

  // whole frame against the reference, then clear the written flags
  task automatic check_frame(input color_pkg::filter_t f);
    int              exp_bin [color_pkg::hist_bins];
    int              exp_total;
    int              bn;
    color_pkg::pxl_t exp_pxl;
    exp_total = 0;
    for (int i = 0; i < color_pkg::hist_bins; i++)
      exp_bin[i] = 0;
    for (int a = 0; a < color_pkg::img_pxls; a++) begin
      assert (wr_cnt[a] == 1)
        else value_error($sformatf("write count of address %0d", a), wr_cnt[a], 1);
      exp_pxl = filter_pass(orig_mem[a], f) ? orig_mem[a] : '0;
      assert (proc_mem[a] == exp_pxl)
        else value_error($sformatf("proc_pxl_o at %0d", a), proc_mem[a], exp_pxl);
      bn = bin_of(a);
      if (bn >= 0 && filter_pass(orig_mem[a], f)) begin
        exp_bin[bn]++;
        exp_total++;
      end
      wr_cnt[a] = 0;
    end
    for (int i = 0; i < color_pkg::hist_bins; i++)
      assert (hist_o[i] == exp_bin[i])
        else value_error($sformatf("hist_o[%0d]", i), hist_o[i], exp_bin[i]);
    assert (color_total_o == exp_total)
      else value_error("color_total_o", color_total_o, exp_total);
  endtask

  task automatic run_frame(input color_pkg::filter_t f);
    start_frame(f);
    wait_done();
    check_frame(f);
  endtask

  // explicit bin values for images with a known answer
  task automatic expect_bins(input int inner_cnt, input bit [7:0] full);
    for (int i = 0; i < color_pkg::hist_bins; i++)
      assert (hist_o[i] == (full[i] ? inner_cnt : 0))
        else value_error($sformatf("hist_o[%0d]", i), hist_o[i], full[i] ? inner_cnt : 0);
  endtask

  initial begin
    void'($urandom(seed));
    rst         = 1'b1;
    new_frame_i = 1'b0;
    filter_i    = color_pkg::filt_none;
    orig_pxl_i  = '0;
    for (int a = 0; a < color_pkg::img_pxls; a++)
      wr_cnt[a] = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // quiet outputs and cleared results after reset
    assert (proc_we_o == 1'b0) else value_error("proc_we_o", proc_we_o, 0);
    assert (frame_done_o == 1'b0) else value_error("frame_done_o", frame_done_o, 0);
    expect_bins(0, 8'h00);
    assert (color_total_o == 0) else value_error("color_total_o", color_total_o, 0);

    for (int a = 0; a < color_pkg::img_pxls; a++)
      orig_mem[a] = color_pkg::pxl_t'($urandom());
    run_frame(color_pkg::filt_none);                // every inner pixel counts
    expect_bins(color_pkg::bin_max, 8'hff);
    assert (color_total_o == color_pkg::inner_pxls)
      else value_error("color_total_o", color_total_o, color_pkg::inner_pxls);
    for (int f = 1; f < 8; f++)
      run_frame(color_pkg::filter_t'(f));

    // red only on the border, inner frame mid gray
    for (int a = 0; a < color_pkg::img_pxls; a++)
      orig_mem[a] = (bin_of(a) < 0) ? 12'hf00 : 12'h888;
    run_frame(color_pkg::filt_red);
    expect_bins(0, 8'h00);
    // red stripes over the first and last bin, black elsewhere
    for (int a = 0; a < color_pkg::img_pxls; a++)
      orig_mem[a] = (bin_of(a) == 0 || bin_of(a) == 7) ? 12'hf00 : 12'h000;
    run_frame(color_pkg::filt_red);
    expect_bins(color_pkg::bin_max, 8'h81);

    // mid-scan pulse is dropped, next frame starts right after the scan
    for (int a = 0; a < color_pkg::img_pxls; a++)
      orig_mem[a] = color_pkg::pxl_t'($urandom());
    start_frame(color_pkg::filt_grn);
    wait_addr(5000);
    new_frame_i = 1'b1;
    filter_i    = color_pkg::filt_blu;
    @(negedge clk);
    new_frame_i = 1'b0;
    wait_addr(color_pkg::img_pxls - 1);
    new_frame_i = 1'b1;                             // held over the last read edge
    filter_i    = color_pkg::filt_cya;
    @(negedge clk);
    @(negedge clk);
    new_frame_i = 1'b0;
    wait_done();
    check_frame(color_pkg::filt_grn);
    wait_done();
    check_frame(color_pkg::filt_cya);

    $display("all tests passed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+tests
rtl/color_pkg.sv
rtl/frame_scan.sv
rtl/color_classify.sv
rtl/hist_accum.sv
rtl/color_proc.sv
tests/tb_color_proc.sv

/* Makefile */
# Verilator build of the color filter testbench
VERILATOR ?= verilator
TOP       ?= tb_color_proc
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
